//--- include/rv_exe_config.svh
`ifndef RV_EXE_CONFIG_SVH
`define RV_EXE_CONFIG_SVH

// data path and register file
`define EXE_XLEN            32
`define EXE_REG_ADDR_WIDTH  5

// one extra bit so signed and unsigned operands share the same units
`define EXE_EXT_WIDTH       33

// addi x0, x0, 0
`define EXE_INST_NOP        32'h0000_0013

// set to 0 to build without the multiply/divide units
`define EXE_HAS_RV32M       1

`endif

//--- design/rv_exe_pkg.sv
`include "rv_exe_config.svh"

package rv_exe_pkg;

    typedef logic [`EXE_XLEN-1:0]           word_t;
    typedef logic [`EXE_EXT_WIDTH-1:0]      ext_word_t;
    typedef logic [2*`EXE_EXT_WIDTH-1:0]    dword_t;
    typedef logic [`EXE_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [3:0]                     mem_wen_t;

    typedef enum logic [4:0] {
        // single cycle arithmetic and logic
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_jalr,
        op_copy1,
        // branches
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        // multiply group
        op_mul,
        op_mulh,
        op_mulhsu,
        op_mulhu,
        // divide group
        op_div,
        op_divu,
        op_rem,
        op_remu,
        op_none
    } exe_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } unit_state_e;

    // decode to execute
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        exe_op_e   op;
        word_t     op1;
        word_t     op2;
        word_t     rs2_data;
        word_t     imm_b;
        logic      rf_wen;
        reg_addr_t wb_addr;
        mem_wen_t  mem_wen;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     alu_out;
        word_t     rs2_data;
        logic      rf_wen;
        reg_addr_t wb_addr;
        mem_wen_t  mem_wen;
    } ex_mem_t;

endpackage

//--- design/alu.sv
module alu
    import rv_exe_pkg::*;
(
    input  exe_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    taken
);

    logic [4:0] shamt;
    word_t      sum;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            op_add: begin
                result = sum;
            end
            op_sub: begin
                result = a - b;
            end
            op_and: begin
                result = a & b;
            end
            op_or: begin
                result = a | b;
            end
            op_xor: begin
                result = a ^ b;
            end
            op_sll: begin
                result = a << shamt;
            end
            op_srl: begin
                result = a >> shamt;
            end
            op_sra: begin
                result = word_t'($signed(a) >>> shamt);
            end
            op_slt: begin
                result = word_t'(lt_s);
            end
            op_sltu: begin
                result = word_t'(lt_u);
            end
            op_jalr: begin
                // target is always halfword aligned
                result = {sum[$bits(word_t)-1:1], 1'b0};
            end
            op_copy1: begin
                result = a;
            end
            op_beq:  taken = eq;
            op_bne:  taken = !eq;
            op_blt:  taken = lt_s;
            op_bge:  taken = !lt_s;
            op_bltu: taken = lt_u;
            op_bgeu: taken = !lt_u;
            default: begin
                result = '0;
                taken  = 1'b0;
            end
        endcase
    end

endmodule

//--- design/mul_unit.sv
`include "rv_exe_config.svh"

module mul_unit
    import rv_exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  ext_word_t a,
    input  ext_word_t b,
    output logic      ready,
    output logic      done,
    output dword_t    product
);

    localparam int cw = $clog2(`EXE_EXT_WIDTH);
    localparam logic [cw-1:0] last_cnt = cw'(`EXE_EXT_WIDTH - 1);

    unit_state_e   state;
    logic [cw-1:0] cnt;
    logic          last;
    dword_t        mcand;
    ext_word_t     mplier;

    assign ready = (state == st_idle);
    assign done  = (state == st_done);
    assign last  = (cnt == last_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        cnt   <= '0;
                    end
                end
                st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (ready && start) begin
            product <= '0;
            mcand   <= {{`EXE_EXT_WIDTH{a[`EXE_EXT_WIDTH-1]}}, a};
            mplier  <= b;
        end else if (state == st_busy) begin
            if (mplier[0]) begin
                // top bit of b carries negative weight
                product <= last ? product - mcand : product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // caller must wait for ready
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> state == st_idle
    );

endmodule

//--- design/div_unit.sv
`include "rv_exe_config.svh"

module div_unit
    import rv_exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      is_signed,
    input  ext_word_t dividend,
    input  ext_word_t divisor,
    output logic      ready,
    output logic      done,
    output word_t     quotient,
    output word_t     remainder
);

    localparam int msb = `EXE_EXT_WIDTH - 1;
    localparam int cw  = $clog2(`EXE_EXT_WIDTH);
    localparam logic [cw-1:0] last_cnt = cw'(`EXE_EXT_WIDTH - 1);

    unit_state_e         state;
    logic [cw-1:0]       cnt;
    // dividend bits shift out the top, quotient bits shift in below
    ext_word_t           quo;
    logic [msb+1:0]      rem;
    ext_word_t           dvs;
    logic [msb+1:0]      trial;
    logic                neg_q;
    logic                neg_r;

    function automatic ext_word_t mag(input ext_word_t v);
        return v[msb] ? -v : v;
    endfunction

    assign ready = (state == st_idle);
    assign done  = (state == st_done);
    assign trial = {rem[msb:0], quo[msb]} - {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        cnt   <= '0;
                    end
                end
                st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == last_cnt) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ready && start) begin
            quo   <= mag(dividend);
            dvs   <= mag(divisor);
            rem   <= '0;
            // x/0 keeps the all-ones quotient unsigned
            neg_q <= is_signed && (dividend[msb] ^ divisor[msb]) && (divisor != '0);
            neg_r <= is_signed && dividend[msb];
        end else if (state == st_busy) begin
            if (!trial[msb+1]) begin
                rem <= trial;
                quo <= {quo[msb-1:0], 1'b1};
            end else begin
                rem <= {rem[msb:0], quo[msb]};
                quo <= {quo[msb-1:0], 1'b0};
            end
        end
    end

    // remainder takes the dividend's sign
    assign quotient  = neg_q ? -quo[`EXE_XLEN-1:0] : quo[`EXE_XLEN-1:0];
    assign remainder = neg_r ? -rem[`EXE_XLEN-1:0] : rem[`EXE_XLEN-1:0];

    // caller must wait for ready
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> state == st_idle
    );

endmodule

//--- design/exe_stage.sv
`include "rv_exe_config.svh"

module exe_stage
    import rv_exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  id_ex_t    in,
    input  logic      flush,
    input  logic      mem_stall,
    output logic      stall,
    output ex_mem_t   out,
    output logic      br_flg,
    output word_t     br_target,
    output logic      hazard_rf_wen,
    output reg_addr_t hazard_wb_addr
);

    localparam bit has_m = `EXE_HAS_RV32M;
    localparam ex_mem_t bubble = '{
        pc:       '0,
        inst:     `EXE_INST_NOP,
        alu_out:  '0,
        rs2_data: '0,
        rf_wen:   1'b0,
        wb_addr:  '0,
        mem_wen:  '0
    };

    id_ex_t    saved;
    logic      use_saved;
    id_ex_t    cur;
    word_t     alu_result;
    logic      alu_taken;
    logic      is_mul;
    logic      is_div;
    logic      is_multi;
    logic      a_signed;
    logic      b_signed;
    ext_word_t ext_a;
    ext_word_t ext_b;
    logic      started;
    logic      finished;
    logic      unit_ready;
    logic      calc_valid;
    word_t     unit_result;
    word_t     kept;
    word_t     exe_result;
    logic      emit_bubble;

    logic      mul_start;
    logic      mul_ready;
    logic      mul_done;
    ext_word_t mul_a;
    ext_word_t mul_b;
    dword_t    mul_product;
    logic      div_start;
    logic      div_signed;
    logic      div_ready;
    logic      div_done;
    ext_word_t div_a;
    ext_word_t div_b;
    word_t     div_quotient;
    word_t     div_remainder;

    // held copy while stalled, fresh input otherwise
    assign cur = use_saved ? saved : in;

    alu u_alu (
        .op     (cur.op),
        .a      (cur.op1),
        .b      (cur.op2),
        .result (alu_result),
        .taken  (alu_taken)
    );

    assign is_mul   = has_m && (cur.op inside {op_mul, op_mulh, op_mulhsu, op_mulhu});
    assign is_div   = has_m && (cur.op inside {op_div, op_divu, op_rem, op_remu});
    assign is_multi = is_mul || is_div;

    // mul low word is the same either way
    assign a_signed = cur.op inside {op_mulh, op_mulhsu, op_div, op_rem};
    assign b_signed = cur.op inside {op_mulh, op_div, op_rem};
    assign ext_a    = {a_signed & cur.op1[`EXE_XLEN-1], cur.op1};
    assign ext_b    = {b_signed & cur.op2[`EXE_XLEN-1], cur.op2};

    assign unit_ready = is_mul ? mul_ready : div_ready;
    // done of a flushed operation is ignored since started was cleared
    assign calc_valid = started && (is_mul ? mul_done : div_done);
    assign stall      = is_multi && !(finished || calc_valid);

    always_comb begin
        case (cur.op)
            op_mul:                       unit_result = mul_product[`EXE_XLEN-1:0];
            op_mulh, op_mulhsu, op_mulhu: unit_result = mul_product[2*`EXE_XLEN-1:`EXE_XLEN];
            op_div, op_divu:              unit_result = div_quotient;
            op_rem, op_remu:              unit_result = div_remainder;
            default:                      unit_result = '0;
        endcase
    end

    assign exe_result = is_multi ? (finished ? kept : unit_result) : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            use_saved <= 1'b0;
            started   <= 1'b0;
            finished  <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else if (flush) begin
            use_saved <= 1'b0;
            started   <= 1'b0;
            finished  <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            use_saved <= stall || mem_stall;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            if (calc_valid) begin
                started  <= 1'b0;
                // result waits here if memory is stalled
                finished <= mem_stall;
            end else if (finished && !mem_stall) begin
                finished <= 1'b0;
            end else if (is_multi && !started && !finished && unit_ready) begin
                started   <= 1'b1;
                mul_start <= is_mul;
                div_start <= is_div;
            end
        end
    end

    always_ff @(posedge clk) begin
        saved <= cur;
        if (calc_valid) begin
            kept <= unit_result;
        end
        if (is_multi && !started && !finished) begin
            mul_a      <= ext_a;
            mul_b      <= ext_b;
            div_a      <= ext_a;
            div_b      <= ext_b;
            div_signed <= a_signed;
        end
    end

    generate
        if (has_m) begin : g_rv32m
            mul_unit u_mul (
                .clk     (clk),
                .rst_n   (rst_n),
                .start   (mul_start),
                .a       (mul_a),
                .b       (mul_b),
                .ready   (mul_ready),
                .done    (mul_done),
                .product (mul_product)
            );

            div_unit u_div (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (div_start),
                .is_signed (div_signed),
                .dividend  (div_a),
                .divisor   (div_b),
                .ready     (div_ready),
                .done      (div_done),
                .quotient  (div_quotient),
                .remainder (div_remainder)
            );
        end else begin : g_no_rv32m
            assign mul_ready     = 1'b0;
            assign mul_done      = 1'b0;
            assign mul_product   = '0;
            assign div_ready     = 1'b0;
            assign div_done      = 1'b0;
            assign div_quotient  = '0;
            assign div_remainder = '0;
        end
    endgenerate

    assign emit_bubble = flush || mem_stall || stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out    <= bubble;
            br_flg <= 1'b0;
        end else begin
            br_flg <= !emit_bubble && alu_taken;
            if (emit_bubble) begin
                out <= bubble;
            end else begin
                out.pc       <= cur.pc;
                out.inst     <= cur.inst;
                out.alu_out  <= exe_result;
                out.rs2_data <= cur.rs2_data;
                out.rf_wen   <= cur.rf_wen;
                out.wb_addr  <= cur.wb_addr;
                out.mem_wen  <= cur.mem_wen;
            end
        end
    end

    always_ff @(posedge clk) begin
        br_target <= cur.pc + cur.imm_b;
    end

    assign hazard_rf_wen  = flush ? 1'b0 : cur.rf_wen;
    assign hazard_wb_addr = flush ? '0 : cur.wb_addr;

    // stall only comes from the M group and that op stays held
    a_stall_holds_m_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall && !flush |=> use_saved && is_multi
    );

endmodule

//--- bench/exe_stage_tb.sv
`include "rv_exe_config.svh"

module exe_stage_tb
    import rv_exe_pkg::*;
();

    localparam word_t nop_inst   = `EXE_INST_NOP;
    localparam int    wait_limit = 200;
    localparam word_t corners [5] = '{
        32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff
    };

    typedef struct packed {
        ex_mem_t bundle;
        logic    br_flg;
        word_t   br_target;
    } expect_t;

    logic      clk;
    logic      rst_n;
    id_ex_t    in;
    logic      flush;
    logic      mem_stall;
    logic      stall;
    ex_mem_t   out;
    logic      br_flg;
    word_t     br_target;
    logic      hazard_rf_wen;
    reg_addr_t hazard_wb_addr;

    expect_t   expected_q[$];
    logic      expect_bubble;
    int        seq      = 0;
    int        checks   = 0;
    int        errors   = 0;
    int        timeouts = 0;

    exe_stage u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in             (in),
        .flush          (flush),
        .mem_stall      (mem_stall),
        .stall          (stall),
        .out            (out),
        .br_flg         (br_flg),
        .br_target      (br_target),
        .hazard_rf_wen  (hazard_rf_wen),
        .hazard_wb_addr (hazard_wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // RISC-V rules, multiply and divide in 64-bit integers
    function automatic expect_t ref_exe(input id_ex_t d);
        expect_t            e;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] prod;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        uprod;
        word_t              a;
        word_t              b;
        word_t              res;
        logic               taken;
        a     = d.op1;
        b     = d.op2;
        sa    = {{32{a[31]}}, a};
        sb    = {{32{b[31]}}, b};
        ua    = {32'h0, a};
        ub    = {32'h0, b};
        res   = '0;
        taken = 1'b0;
        case (d.op)
            op_add:   res = a + b;
            op_sub:   res = a - b;
            op_and:   res = a & b;
            op_or:    res = a | b;
            op_xor:   res = a ^ b;
            op_sll:   res = a << b[4:0];
            op_srl:   res = a >> b[4:0];
            op_sra:   res = word_t'(sa >>> b[4:0]);
            op_slt:   res = (sa < sb) ? 32'd1 : 32'd0;
            op_sltu:  res = (a < b) ? 32'd1 : 32'd0;
            op_jalr:  res = (a + b) & ~32'h1;
            op_copy1: res = a;
            op_beq:   taken = (a == b);
            op_bne:   taken = (a != b);
            op_blt:   taken = (sa < sb);
            op_bge:   taken = (sa >= sb);
            op_bltu:  taken = (a < b);
            op_bgeu:  taken = (a >= b);
            op_mul: begin
                prod = sa * sb;
                res  = prod[31:0];
            end
            op_mulh: begin
                prod = sa * sb;
                res  = prod[63:32];
            end
            op_mulhsu: begin
                prod = sa * $signed(ub);
                res  = prod[63:32];
            end
            op_mulhu: begin
                uprod = ua * ub;
                res   = uprod[63:32];
            end
            op_div: begin
                if (b == '0) begin
                    res = 32'hffff_ffff;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    res = a;
                end else begin
                    prod = sa / sb;
                    res  = prod[31:0];
                end
            end
            op_rem: begin
                if (b == '0) begin
                    res = a;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    res = '0;
                end else begin
                    prod = sa % sb;
                    res  = prod[31:0];
                end
            end
            op_divu: begin
                uprod = (b == '0) ? 64'hffff_ffff : ua / ub;
                res   = uprod[31:0];
            end
            op_remu: begin
                uprod = (b == '0) ? ua : ua % ub;
                res   = uprod[31:0];
            end
            default: res = '0;
        endcase
        e.bundle.pc       = d.pc;
        e.bundle.inst     = d.inst;
        e.bundle.alu_out  = res;
        e.bundle.rs2_data = d.rs2_data;
        e.bundle.rf_wen   = d.rf_wen;
        e.bundle.wb_addr  = d.wb_addr;
        e.bundle.mem_wen  = d.mem_wen;
        e.br_flg          = taken;
        e.br_target       = d.pc + d.imm_b;
        return e;
    endfunction

    function automatic id_ex_t idle_instr();
        id_ex_t d;
        d      = '0;
        d.op   = op_none;
        d.inst = nop_inst;
        return d;
    endfunction

    function automatic logic is_bubble_out(input ex_mem_t o);
        return !o.rf_wen && o.inst == nop_inst;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    // one compare step per cycle, outputs are stable at the falling edge
    task automatic monitor_cycle();
        expect_t e;
        if (expect_bubble) begin
            check_value("out.inst", out.inst, nop_inst);
            check_value("out.rf_wen", word_t'(out.rf_wen), '0);
            check_value("out.mem_wen", word_t'(out.mem_wen), '0);
            check_value("br_flg", word_t'(br_flg), '0);
        end else if (!is_bubble_out(out)) begin
            checks++;
            assert (expected_q.size() > 0) else begin
                errors++;
                $display("result for inst %h appeared with no instruction pending", out.inst);
            end
            if (expected_q.size() > 0) begin
                e = expected_q.pop_front();
                check_value("out.inst", out.inst, e.bundle.inst);
                check_value("out.pc", out.pc, e.bundle.pc);
                check_value("out.alu_out", out.alu_out, e.bundle.alu_out);
                check_value("out.rs2_data", out.rs2_data, e.bundle.rs2_data);
                check_value("out.rf_wen", word_t'(out.rf_wen), word_t'(e.bundle.rf_wen));
                check_value("out.wb_addr", word_t'(out.wb_addr), word_t'(e.bundle.wb_addr));
                check_value("out.mem_wen", word_t'(out.mem_wen), word_t'(e.bundle.mem_wen));
                check_value("br_flg", word_t'(br_flg), word_t'(e.br_flg));
                check_value("br_target", br_target, e.br_target);
            end
        end
        if (flush) begin
            check_value("hazard_rf_wen", word_t'(hazard_rf_wen), '0);
            check_value("hazard_wb_addr", word_t'(hazard_wb_addr), '0);
        end else begin
            check_value("hazard_rf_wen", word_t'(hazard_rf_wen), word_t'(in.rf_wen));
            check_value("hazard_wb_addr", word_t'(hazard_wb_addr), word_t'(in.wb_addr));
        end
        // decode holds its bundle, so in is what the next edge takes
        expect_bubble = flush || mem_stall || stall;
        if (!expect_bubble && !(in.inst == nop_inst && !in.rf_wen)) begin
            expected_q.push_back(ref_exe(in));
        end
    endtask

    initial begin
        expect_bubble = 1'b1;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                monitor_cycle();
            end
        end
    end

    task automatic build_instr(input exe_op_e op, input word_t a, input word_t b,
                               output id_ex_t d);
        word_t r;
        seq++;
        r          = $urandom;
        d.pc       = $urandom & 32'hffff_fffc;
        // sequence number keeps every inst unique and never a nop
        d.inst     = {seq[24:0], 7'h33};
        d.op       = op;
        d.op1      = a;
        d.op2      = b;
        d.rs2_data = $urandom;
        d.imm_b    = $urandom;
        d.rf_wen   = r[0];
        d.wb_addr  = r[5:1];
        d.mem_wen  = r[9:6];
    endtask

    task automatic issue_instr(input id_ex_t d);
        int n;
        n = 0;
        @(posedge clk);
        in <= d;
        @(negedge clk);
        while (stall || mem_stall || flush) begin
            if (n == wait_limit) begin
                note_timeout("an instruction to be accepted");
                break;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic run_op(input exe_op_e op, input word_t a, input word_t b);
        id_ex_t d;
        build_instr(op, a, b, d);
        issue_instr(d);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in <= idle_instr();
    endtask

    task automatic wait_stall_rise();
        int n;
        n = 0;
        @(negedge clk);
        while (!stall) begin
            if (n == wait_limit) begin
                note_timeout("stall to rise");
                break;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic random_mem_stall(input int cycles);
        int   elapsed;
        int   span;
        logic level;
        elapsed = 0;
        while (elapsed < cycles) begin
            span  = $urandom_range(1, 8);
            level = ($urandom_range(0, 2) == 0);
            repeat (span) begin
                @(posedge clk);
                mem_stall <= level;
            end
            elapsed += span;
        end
        @(posedge clk);
        mem_stall <= 1'b0;
    endtask

    initial begin
        id_ex_t  d;
        exe_op_e op;
        int      i;
        int      j;
        int      k;
        int      n;
        void'($urandom(32'h766a));
        in        <= idle_instr();
        flush     <= 1'b0;
        mem_stall <= 1'b0;
        rst_n     <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("stall", word_t'(stall), '0);
        check_value("br_flg", word_t'(br_flg), '0);
        check_value("out.rf_wen", word_t'(out.rf_wen), '0);
        check_value("out.mem_wen", word_t'(out.mem_wen), '0);
        check_value("mul_start", word_t'(u_dut.mul_start), '0);
        check_value("div_start", word_t'(u_dut.div_start), '0);
        check_value("mul_ready", word_t'(u_dut.mul_ready), 32'h1);
        check_value("div_ready", word_t'(u_dut.div_ready), 32'h1);

        // single cycle arithmetic and logic
        for (i = 0; i < 40; i++) begin
            op = exe_op_e'($urandom_range(int'(op_add), int'(op_copy1)));
            run_op(op, $urandom, $urandom);
        end

        // branches
        for (i = 0; i < 6; i++) begin
            op = exe_op_e'(int'(op_beq) + i);
            run_op(op, $urandom, $urandom);
            d.op1 = $urandom;
            run_op(op, d.op1, d.op1);
            for (j = 0; j < 5; j++) begin
                run_op(op, corners[j], corners[(j + 1) % 5]);
            end
        end

        // multiply then divide, corner grid plus random
        for (i = 0; i < 8; i++) begin
            op = exe_op_e'(int'(op_mul) + i);
            for (j = 0; j < 5; j++) begin
                for (k = 0; k < 5; k++) begin
                    run_op(op, corners[j], corners[k]);
                end
            end
            for (j = 0; j < 3; j++) begin
                run_op(op, $urandom, $urandom);
            end
        end
        drive_idle();

        // flush in the middle of a multiply
        build_instr(op_mul, 32'h1234_5678, 32'h9abc_def0, d);
        d.rf_wen  = 1'b1;
        d.wb_addr = 5'd7;
        @(posedge clk);
        in <= d;
        wait_stall_rise();
        repeat (6) @(negedge clk);
        @(posedge clk);
        flush <= 1'b1;
        in    <= idle_instr();
        @(posedge clk);
        flush <= 1'b0;
        run_op(op_mul, 32'hffff_fff9, 32'h0000_0011);
        run_op(op_add, $urandom, $urandom);
        drive_idle();

        // memory stall across a divide's completion
        build_instr(op_div, 32'h8000_0000, 32'hffff_ffff, d);
        fork
            issue_instr(d);
            begin
                repeat (8) @(posedge clk);
                mem_stall <= 1'b1;
                repeat (40) @(posedge clk);
                mem_stall <= 1'b0;
            end
        join
        drive_idle();

        fork
            random_mem_stall(300);
            for (i = 0; i < 30; i++) begin
                op = exe_op_e'($urandom_range(int'(op_add), int'(op_remu)));
                run_op(op, $urandom, $urandom);
            end
        join
        drive_idle();

        n = 0;
        @(negedge clk);
        while (expected_q.size() != 0) begin
            if (n == wait_limit) begin
                note_timeout("the last results");
                break;
            end
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/rv_exe_pkg.sv
design/alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exe_stage.sv
bench/exe_stage_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module exe_stage_tb \
    -f files.f \
    -o exe_stage_sim

./obj_dir/exe_stage_sim > sim.log
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
